//--- build.f
design/mem_access_pkg.sv
design/mips_exc_pkg.sv
design/mem1_ifs.sv
design/mem_addr_xlate.sv
design/exc_prioritizer.sv
design/llsc_monitor.sv
design/store_align.sv
design/mem_req_issue.sv
design/mem1_stage.sv
tests/tb_mem1_stage.sv

//--- design/exc_prioritizer.sv
`timescale 1ns/1ns

module exc_prioritizer (
    input  mem_access_pkg::addr_t       vaddr,
    input  mem_access_pkg::addr_t       pc,
    input  logic                        is_load,
    input  logic                        is_store,
    input  mem_access_pkg::size_t       size,
    input  mem_access_pkg::store_kind_t store_kind,
    input  logic                        overflow,
    input  logic                        trap,
    input  logic                        interrupt,
    input  logic                        prev_exc,
    input  mips_exc_pkg::exc_code_t     prev_code,
    xlate_if.consumer                   xl,
    exc_if.producer                     ex
);

    logic misaligned;
    logic ades;
    logic adel;

    // swl/swr are allowed at any offset
    assign misaligned = (store_kind == mem_access_pkg::ST_NORMAL) &&
                        ((size == mem_access_pkg::SIZE_HALF && vaddr[0]) ||
                         (size == mem_access_pkg::SIZE_WORD && vaddr[1:0] != 2'b00));
    assign ades = is_store & misaligned;
    assign adel = is_load & misaligned;

    always_comb begin
        ex.exc_valid = 1'b1;
        ex.exc_code  = prev_code;
        ex.badvaddr  = '0;
        if (interrupt) begin
            ex.exc_code = mips_exc_pkg::EXC_INT;
        end else if (overflow) begin
            ex.exc_code = mips_exc_pkg::EXC_OV;
        end else if (trap) begin
            ex.exc_code = mips_exc_pkg::EXC_TR;
        end else if (ades) begin
            ex.exc_code = mips_exc_pkg::EXC_ADES;
            ex.badvaddr = vaddr;
        end else if (adel) begin
            ex.exc_code = mips_exc_pkg::EXC_ADEL;
            ex.badvaddr = vaddr;
        end else if (xl.tlb_exc) begin
            ex.exc_code = xl.tlb_code;
            ex.badvaddr = vaddr;
        end else if (prev_exc) begin
            ex.badvaddr = pc;   // earlier stages fault on the fetch address
        end else begin
            ex.exc_valid = 1'b0;
        end
    end

    tlb_code_legal: assert final (!xl.tlb_exc || xl.tlb_code == mips_exc_pkg::EXC_MOD ||
        xl.tlb_code == mips_exc_pkg::EXC_TLBL || xl.tlb_code == mips_exc_pkg::EXC_TLBS)
        else $error("tlb exception with code %h", xl.tlb_code);

endmodule

//--- design/llsc_monitor.sv
`timescale 1ns/1ns

module llsc_monitor (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  accept,
    input  mem_access_pkg::addr_t vaddr,
    input  logic                  is_ll,
    input  logic                  is_sc,
    input  logic                  kill,
    exc_if.consumer               ex,
    output logic                  sc_ok
);

    logic                  link;
    mem_access_pkg::addr_t link_addr;
    logic                  set_link;

    assign set_link = accept & is_ll & ~kill & ~ex.exc_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            link <= 1'b0;
        end else if (accept && (kill || ex.exc_valid)) begin
            link <= 1'b0;
        end else if (set_link) begin
            link <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (set_link)
            link_addr <= vaddr;
    end

    assign sc_ok = is_sc & link & (link_addr == vaddr);

endmodule

//--- design/mem1_ifs.sv
`timescale 1ns/1ns

interface xlate_if;
    mem_access_pkg::addr_t   paddr;
    logic                    uncached;
    logic                    tlb_refill;
    logic                    tlb_exc;
    mips_exc_pkg::exc_code_t tlb_code;

    modport producer (output paddr, uncached, tlb_refill, tlb_exc, tlb_code);
    modport consumer (input paddr, uncached, tlb_refill, tlb_exc, tlb_code);
endinterface

interface exc_if;
    logic                    exc_valid;
    mips_exc_pkg::exc_code_t exc_code;
    mem_access_pkg::addr_t   badvaddr;

    modport producer (output exc_valid, exc_code, badvaddr);
    modport consumer (input exc_valid, exc_code, badvaddr);
endinterface

interface store_if;
    logic                  write_en;
    mem_access_pkg::strb_t wstrb;
    mem_access_pkg::word_t wdata;

    modport producer (output write_en, wstrb, wdata);
    modport consumer (input write_en, wstrb, wdata);
endinterface

//--- design/mem1_stage.sv
`timescale 1ns/1ns

module mem1_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  mem_access_pkg::addr_t       vaddr,
    input  mem_access_pkg::addr_t       pc,
    input  logic                        is_load,
    input  logic                        is_store,
    input  mem_access_pkg::size_t       size,
    input  mem_access_pkg::store_kind_t store_kind,
    input  mem_access_pkg::word_t       store_data,
    input  logic                        is_ll,
    input  logic                        is_sc,
    input  logic                        kill,
    input  logic                        overflow,
    input  logic                        trap,
    input  logic                        interrupt,
    input  logic                        prev_exc,
    input  mips_exc_pkg::exc_code_t     prev_code,
    input  logic                        tlb_found,
    input  logic                        tlb_v,
    input  logic                        tlb_d,
    input  mem_access_pkg::pfn_t        tlb_pfn,
    input  mem_access_pkg::cattr_t      tlb_c,
    input  mem_access_pkg::cattr_t      k0_attr,
    output logic                        req_valid,
    input  logic                        req_ready,
    output logic                        req_mem,
    output logic                        req_uncached,
    output logic                        req_write,
    output mem_access_pkg::addr_t       req_paddr,
    output mem_access_pkg::strb_t       req_wstrb,
    output mem_access_pkg::word_t       req_wdata,
    output logic                        exc_valid,
    output mips_exc_pkg::exc_code_t     exc_code,
    output mem_access_pkg::addr_t       badvaddr,
    output logic                        sc_result
);

    logic access;
    logic accept;
    logic sc_ok;

    xlate_if xl_bus ();
    exc_if   ex_bus ();
    store_if st_bus ();

    assign access = is_load | is_store;
    assign accept = in_valid & in_ready;

    mem_addr_xlate xlate_inst (
        .vaddr(vaddr), .access(access), .is_store(is_store),
        .tlb_found(tlb_found), .tlb_v(tlb_v), .tlb_d(tlb_d),
        .tlb_pfn(tlb_pfn), .tlb_c(tlb_c), .k0_attr(k0_attr),
        .prev_exc(prev_exc), .xl(xl_bus)
    );

    exc_prioritizer exc_inst (
        .vaddr(vaddr), .pc(pc), .is_load(is_load), .is_store(is_store),
        .size(size), .store_kind(store_kind), .overflow(overflow), .trap(trap),
        .interrupt(interrupt), .prev_exc(prev_exc), .prev_code(prev_code),
        .xl(xl_bus), .ex(ex_bus)
    );

    llsc_monitor llsc_inst (
        .clk(clk), .rst_n(rst_n), .accept(accept), .vaddr(vaddr),
        .is_ll(is_ll), .is_sc(is_sc), .kill(kill), .ex(ex_bus), .sc_ok(sc_ok)
    );

    store_align store_inst (
        .is_store(is_store), .is_sc(is_sc), .sc_ok(sc_ok), .size(size),
        .store_kind(store_kind), .paddr_low(xl_bus.paddr[1:0]),
        .store_data(store_data), .st(st_bus)
    );

    mem_req_issue issue_inst (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
        .access(access), .kill(kill), .is_sc(is_sc),
        .xl(xl_bus), .ex(ex_bus), .st(st_bus),
        .req_valid(req_valid), .req_ready(req_ready), .req_mem(req_mem),
        .req_uncached(req_uncached), .req_write(req_write), .req_paddr(req_paddr),
        .req_wstrb(req_wstrb), .req_wdata(req_wdata), .exc_valid(exc_valid),
        .exc_code(exc_code), .badvaddr(badvaddr), .sc_result(sc_result)
    );

endmodule

//--- design/mem_access_pkg.sv
package mem_access_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;
    typedef logic [1:0]  size_t;
    typedef logic [1:0]  store_kind_t;

    localparam int PAGE_OFFSET_BITS = 12;
    localparam int SEG_BITS         = 3;

    // upper three address bits
    localparam logic [SEG_BITS-1:0] KSEG0_SEG = 3'd4;
    localparam logic [SEG_BITS-1:0] KSEG1_SEG = 3'd5;

    localparam cattr_t CATTR_CACHED = 3'd3;

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    localparam store_kind_t ST_NORMAL = 2'd0;
    localparam store_kind_t ST_LEFT   = 2'd1;   // swl
    localparam store_kind_t ST_RIGHT  = 2'd2;   // swr

endpackage

//--- design/mem_addr_xlate.sv
`timescale 1ns/1ns

module mem_addr_xlate (
    input  mem_access_pkg::addr_t  vaddr,
    input  logic                   access,
    input  logic                   is_store,
    input  logic                   tlb_found,
    input  logic                   tlb_v,
    input  logic                   tlb_d,
    input  mem_access_pkg::pfn_t   tlb_pfn,
    input  mem_access_pkg::cattr_t tlb_c,
    input  mem_access_pkg::cattr_t k0_attr,
    input  logic                   prev_exc,
    xlate_if.producer              xl
);

    localparam int SEG_LO = $bits(mem_access_pkg::addr_t) - mem_access_pkg::SEG_BITS;

    logic [mem_access_pkg::SEG_BITS-1:0] seg;
    logic mapped;
    logic kseg0;
    logic kseg1;
    logic check;
    logic tlb_inv;
    logic tlb_mod;

    assign seg    = vaddr[SEG_LO +: mem_access_pkg::SEG_BITS];
    assign mapped = ~seg[2] | seg[1];   // kuseg, kseg2, kseg3
    assign kseg0  = seg == mem_access_pkg::KSEG0_SEG;
    assign kseg1  = seg == mem_access_pkg::KSEG1_SEG;

    assign xl.paddr = mapped ? {tlb_pfn, vaddr[mem_access_pkg::PAGE_OFFSET_BITS-1:0]}
                             : {{mem_access_pkg::SEG_BITS{1'b0}}, vaddr[SEG_LO-1:0]};

    always_comb begin
        if (kseg1)
            xl.uncached = 1'b1;
        else if (kseg0)
            xl.uncached = k0_attr != mem_access_pkg::CATTR_CACHED;
        else
            xl.uncached = tlb_c != mem_access_pkg::CATTR_CACHED;
    end

    // tlb result only matters for a mapped access with no older exception
    assign check         = access & mapped & ~prev_exc;
    assign xl.tlb_refill = check & ~tlb_found;
    assign tlb_inv       = check & tlb_found & ~tlb_v;
    assign tlb_mod       = check & tlb_found & tlb_v & ~tlb_d & is_store;
    assign xl.tlb_exc    = xl.tlb_refill | tlb_inv | tlb_mod;

    assign xl.tlb_code = tlb_mod  ? mips_exc_pkg::EXC_MOD  :
                         is_store ? mips_exc_pkg::EXC_TLBS :
                                    mips_exc_pkg::EXC_TLBL;

    unmapped_no_tlb_exc: assert final (!((kseg0 || kseg1) && xl.tlb_exc))
        else $error("tlb exception %h on unmapped address %h", xl.tlb_code, vaddr);

endmodule

//--- design/mem_req_issue.sv
`timescale 1ns/1ns

module mem_req_issue (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  logic                           access,
    input  logic                           kill,
    input  logic                           is_sc,
    xlate_if.consumer                      xl,
    exc_if.consumer                        ex,
    store_if.consumer                      st,
    output logic                           req_valid,
    input  logic                           req_ready,
    output logic                           req_mem,
    output logic                           req_uncached,
    output logic                           req_write,
    output mem_access_pkg::addr_t          req_paddr,
    output mem_access_pkg::strb_t          req_wstrb,
    output mem_access_pkg::word_t          req_wdata,
    output logic                           exc_valid,
    output mips_exc_pkg::exc_code_t        exc_code,
    output mem_access_pkg::addr_t          badvaddr,
    output logic                           sc_result
);

    logic accept;
    logic mem_go;
    logic write_go;

    assign in_ready = ~req_valid | req_ready;   // empty or draining
    assign accept   = in_valid & in_ready;

    // failed sc drops its request through write_en
    assign mem_go   = access & ~ex.exc_valid & ~kill & (~is_sc | st.write_en);
    assign write_go = mem_go & st.write_en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
            req_mem   <= 1'b0;
            req_write <= 1'b0;
            exc_valid <= 1'b0;
            sc_result <= 1'b0;
        end else if (accept) begin
            req_valid <= 1'b1;
            req_mem   <= mem_go;
            req_write <= write_go;
            exc_valid <= ex.exc_valid & ~kill;
            sc_result <= is_sc & mem_go;
        end else if (req_ready) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_uncached <= xl.uncached;
            req_paddr    <= xl.paddr;
            req_wstrb    <= write_go ? st.wstrb : '0;
            req_wdata    <= st.wdata;
            exc_code     <= ex.exc_code;
            badvaddr     <= ex.badvaddr;
        end
    end

    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable({req_mem, req_uncached, req_write,
            req_paddr, req_wstrb, req_wdata, exc_valid, exc_code, badvaddr, sc_result}))
        else $error("output changed while stalled");

    strobe_needs_write: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> (req_wstrb != '0) == req_write)
        else $error("strobe %h does not match write %b", req_wstrb, req_write);

endmodule

//--- design/mips_exc_pkg.sv
package mips_exc_pkg;

    typedef logic [4:0] exc_code_t;

    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_MOD  = 5'd1;
    localparam exc_code_t EXC_TLBL = 5'd2;     // also refill on load
    localparam exc_code_t EXC_TLBS = 5'd3;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;
    localparam exc_code_t EXC_OV   = 5'd12;
    localparam exc_code_t EXC_TR   = 5'd13;

endpackage

//--- design/store_align.sv
`timescale 1ns/1ns

module store_align (
    input  logic                        is_store,
    input  logic                        is_sc,
    input  logic                        sc_ok,
    input  mem_access_pkg::size_t       size,
    input  mem_access_pkg::store_kind_t store_kind,
    input  logic [1:0]                  paddr_low,
    input  mem_access_pkg::word_t       store_data,
    store_if.producer                   st
);

    mem_access_pkg::strb_t strb;

    assign st.write_en = is_store & (~is_sc | sc_ok);

    always_comb begin
        case (store_kind)
            mem_access_pkg::ST_LEFT: begin
                case (paddr_low)
                    2'd0:    strb = 4'b0001;
                    2'd1:    strb = 4'b0011;
                    2'd2:    strb = 4'b0111;
                    default: strb = 4'b1111;
                endcase
            end
            mem_access_pkg::ST_RIGHT: begin
                case (paddr_low)
                    2'd0:    strb = 4'b1111;
                    2'd1:    strb = 4'b1110;
                    2'd2:    strb = 4'b1100;
                    default: strb = 4'b1000;
                endcase
            end
            default: begin
                if (size == mem_access_pkg::SIZE_BYTE)
                    strb = 4'b0001 << paddr_low;
                else if (size == mem_access_pkg::SIZE_HALF)
                    strb = paddr_low[1] ? 4'b1100 : 4'b0011;
                else
                    strb = 4'b1111;
            end
        endcase
    end

    assign st.wstrb = st.write_en ? strb : '0;

    always_comb begin
        if (store_kind == mem_access_pkg::ST_LEFT)
            st.wdata = store_data >> {~paddr_low, 3'b000};  // msbs down to lane 0
        else if (store_kind == mem_access_pkg::ST_RIGHT)
            st.wdata = store_data << {paddr_low, 3'b000};   // lsbs up to lane 3
        else if (size == mem_access_pkg::SIZE_BYTE)
            st.wdata = {4{store_data[7:0]}};
        else if (size == mem_access_pkg::SIZE_HALF)
            st.wdata = {2{store_data[15:0]}};
        else
            st.wdata = store_data;
    end

endmodule

//--- tests/mem1_testdata.hex
// vaddr pc store_data ctrl(ld st size kind ll sc kill k0) exc(ov tr int pe code found v)
// tlb(pfn d c -) then expected paddr wdata flags(mem unc wr strb exc code sc) badvaddr
80001000 00000000 00000000 10200003 00000000 00000000 00001000 00000000 10000000 00000000
80002004 00000000 00000000 10200002 00000000 00000000 00002004 00000000 11000000 00000000
a0003008 00000000 00000000 10200003 00000000 00000000 00003008 00000000 11000000 00000000
00400abc 00000000 00000000 10200003 00000011 12345030 12345abc 00000000 10000000 00000000
c0001ff0 00000000 00000000 10200003 00000011 00abc020 00abcff0 00000000 11000000 00000000
80000100 00000000 11223344 01000003 00000000 00000000 00000100 44444444 10110000 00000000
80000101 00000000 11223344 01000003 00000000 00000000 00000101 44444444 10120000 00000000
80000102 00000000 11223344 01000003 00000000 00000000 00000102 44444444 10140000 00000000
80000103 00000000 11223344 01000003 00000000 00000000 00000103 44444444 10180000 00000000
80000100 00000000 11223344 01100003 00000000 00000000 00000100 33443344 10130000 00000000
80000102 00000000 11223344 01100003 00000000 00000000 00000102 33443344 101c0000 00000000
80000100 00000000 11223344 01200003 00000000 00000000 00000100 11223344 101f0000 00000000
80000100 00000000 11223344 01210003 00000000 00000000 00000100 00000011 10110000 00000000
80000101 00000000 11223344 01210003 00000000 00000000 00000101 00001122 10130000 00000000
80000102 00000000 11223344 01210003 00000000 00000000 00000102 00112233 10170000 00000000
80000103 00000000 11223344 01210003 00000000 00000000 00000103 11223344 101f0000 00000000
80000100 00000000 11223344 01220003 00000000 00000000 00000100 11223344 101f0000 00000000
80000101 00000000 11223344 01220003 00000000 00000000 00000101 22334400 101e0000 00000000
80000102 00000000 11223344 01220003 00000000 00000000 00000102 33440000 101c0000 00000000
80000103 00000000 11223344 01220003 00000000 00000000 00000103 44000000 10180000 00000000
80000200 00000000 00000000 10200003 11100000 00000000 00000000 00000000 00001000 00000000
80000201 00000000 11223344 01200003 11000000 00000000 00000000 00000000 000010c0 00000000
80000204 00400000 00000000 10200003 01010a00 00000000 00000000 00000000 000010d0 00000000
80000301 00400004 11223344 01100003 00010a00 00000000 00000000 00000000 00001050 80000301
80000302 00000000 00000000 10200003 00000000 00000000 00000000 00000000 00001040 80000302
00401000 00000000 00000000 10200003 00000000 00000000 00000000 00000000 00001020 00401000
00402000 00000000 11223344 01200003 00000010 00000000 00000000 00000000 00001030 00402000
7ffff000 00000000 11223344 01200003 00000011 00123030 00000000 00000000 00001010 7ffff000
80000400 00400010 00000000 10200003 00010a00 00000000 00000000 00000000 000010a0 00400010
00500000 00400020 00000000 10200003 00010800 00000000 00000000 00000000 00001080 00400020
80000800 00000000 00000000 10201003 00000000 00000000 00000800 00000000 10000000 00000000
80000800 00000000 cafef00d 01200103 00000000 00000000 00000800 cafef00d 101f0001 00000000
80000804 00000000 12345678 01200103 00000000 00000000 00000000 00000000 00000000 00000000
80000900 00000000 00000000 10201013 00000000 00000000 00000000 00000000 00000000 00000000
80000800 00000000 cafef00d 01200103 00000000 00000000 00000000 00000000 00000000 00000000
80000a00 00000000 00000000 10201003 00000000 00000000 00000a00 00000000 10000000 00000000
80000b00 00000000 00000000 10200003 10000000 00000000 00000000 00000000 000010c0 00000000
80000a00 00000000 cafef00d 01200103 00000000 00000000 00000000 00000000 00000000 00000000
80000d00 00000000 00000000 10200013 00100000 00000000 00000000 00000000 00000000 00000000

//--- tests/tb_mem1_stage.sv
`timescale 1ns/1ns

module tb_mem1_stage;

    localparam int CLK_PERIOD = 20;
    localparam int N_OPS      = 39;
    localparam int WORDS      = 10;   // hex words per data line
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic [31:0] tdata [0:N_OPS*WORDS-1];

    logic                        clk;
    logic                        rst_n;
    logic                        in_valid;
    logic                        in_ready;
    mem_access_pkg::addr_t       vaddr;
    mem_access_pkg::addr_t       pc;
    logic                        is_load;
    logic                        is_store;
    mem_access_pkg::size_t       size;
    mem_access_pkg::store_kind_t store_kind;
    mem_access_pkg::word_t       store_data;
    logic                        is_ll;
    logic                        is_sc;
    logic                        kill;
    logic                        overflow;
    logic                        trap;
    logic                        interrupt;
    logic                        prev_exc;
    mips_exc_pkg::exc_code_t     prev_code;
    logic                        tlb_found;
    logic                        tlb_v;
    logic                        tlb_d;
    mem_access_pkg::pfn_t        tlb_pfn;
    mem_access_pkg::cattr_t      tlb_c;
    mem_access_pkg::cattr_t      k0_attr;
    logic                        req_valid;
    logic                        req_ready;
    logic                        req_mem;
    logic                        req_uncached;
    logic                        req_write;
    mem_access_pkg::addr_t       req_paddr;
    mem_access_pkg::strb_t       req_wstrb;
    mem_access_pkg::word_t       req_wdata;
    logic                        exc_valid;
    mips_exc_pkg::exc_code_t     exc_code;
    mem_access_pkg::addr_t       badvaddr;
    logic                        sc_result;

    logic [31:0]  lfsr = 32'hdf7c_42f6;
    int           next_op = 0;
    int           received = 0;
    int           errors = 0;
    int           checks = 0;
    int           exp_q[$];
    logic         stalled = 1'b0;
    logic [109:0] held;

    mem1_stage mem1_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s >> 1;
        if (s[0])
            lfsr_next = lfsr_next ^ LFSR_TAPS;
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    function automatic logic [109:0] out_snapshot();
        out_snapshot = {req_mem, req_uncached, req_write, req_paddr, req_wstrb, req_wdata,
                        exc_valid, exc_code, badvaddr, sc_result};
    endfunction

    task automatic apply_op(input int idx);
        logic [31:0] c;
        logic [31:0] e;
        logic [31:0] t;
        c = tdata[idx*WORDS+3];
        e = tdata[idx*WORDS+4];
        t = tdata[idx*WORDS+5];
        vaddr      <= tdata[idx*WORDS];
        pc         <= tdata[idx*WORDS+1];
        store_data <= tdata[idx*WORDS+2];
        is_load    <= c[28];
        is_store   <= c[24];
        size       <= c[21:20];
        store_kind <= c[17:16];
        is_ll      <= c[12];
        is_sc      <= c[8];
        kill       <= c[4];
        k0_attr    <= c[2:0];
        overflow   <= e[28];
        trap       <= e[24];
        interrupt  <= e[20];
        prev_exc   <= e[16];
        prev_code  <= e[12:8];
        tlb_found  <= e[4];
        tlb_v      <= e[0];
        tlb_pfn    <= t[31:12];
        tlb_d      <= t[8];
        tlb_c      <= t[6:4];
    endtask

    task automatic check_field(input int idx, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error: op %0d %s got %h expected %h", idx, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_out(input int idx);
        logic [31:0] f;
        f = tdata[idx*WORDS+8];
        check_field(idx, "req_mem", req_mem, f[28]);
        check_field(idx, "req_write", req_write, f[20]);
        check_field(idx, "req_wstrb", req_wstrb, f[19:16]);
        check_field(idx, "exc_valid", exc_valid, f[12]);
        check_field(idx, "sc_result", sc_result, f[0]);
        if (f[28]) begin   // address and data only matter for a real request
            check_field(idx, "req_paddr", req_paddr, tdata[idx*WORDS+6]);
            check_field(idx, "req_uncached", req_uncached, f[24]);
            check_field(idx, "req_wdata", req_wdata, tdata[idx*WORDS+7]);
        end
        if (f[12]) begin
            check_field(idx, "exc_code", exc_code, f[8:4]);
            check_field(idx, "badvaddr", badvaddr, tdata[idx*WORDS+9]);
        end
    endtask

    always @(posedge clk) begin
        logic gap;
        logic rdy;
        if (rst_n) begin
            if (stalled) begin
                checks++;
                assert (req_valid && out_snapshot() == held) else begin
                    $display("outputs changed while the request was stalled");
                    errors++;
                end
            end
            checks++;
            assert (in_ready == !(req_valid && !req_ready)) else begin
                $display("error: in_ready got %h expected %h",
                         in_ready, !(req_valid && !req_ready));
                errors++;
            end
            if (req_valid && req_ready) begin
                checks++;
                assert (exp_q.size() != 0) else begin
                    $display("output transfer with no operation in flight");
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    compare_out(exp_q.pop_front());
                    received++;
                end
            end
            stalled = req_valid && !req_ready;
            held    = out_snapshot();
            if (in_valid && in_ready) begin
                exp_q.push_back(next_op);
                next_op++;
            end
            if (!(in_valid && !in_ready)) begin
                take_bit(gap);
                if (next_op < N_OPS && !gap) begin
                    apply_op(next_op);
                    in_valid <= 1'b1;
                end else begin
                    in_valid <= 1'b0;
                end
            end
            take_bit(rdy);
            req_ready <= rdy;
        end
    end

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        req_ready = 1'b0;
        vaddr = '0;
        pc = '0;
        is_load = 1'b0;
        is_store = 1'b0;
        size = '0;
        store_kind = '0;
        store_data = '0;
        is_ll = 1'b0;
        is_sc = 1'b0;
        kill = 1'b0;
        overflow = 1'b0;
        trap = 1'b0;
        interrupt = 1'b0;
        prev_exc = 1'b0;
        prev_code = '0;
        tlb_found = 1'b0;
        tlb_v = 1'b0;
        tlb_d = 1'b0;
        tlb_pfn = '0;
        tlb_c = '0;
        k0_attr = 3'd3;
        $readmemh("tests/mem1_testdata.hex", tdata);
        assert (tdata[N_OPS*WORDS-1] !== 'x) else begin
            $display("test data file is missing or shorter than expected");
            errors++;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        wait (received == N_OPS);
        repeat (2) @(posedge clk);
        $display("checks %0d errors %0d received %0d of %0d", checks, errors, received, N_OPS);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(40 * N_OPS * CLK_PERIOD);
        $display("timeout after %0d of %0d operations, errors %0d", received, N_OPS, errors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
